// ==== logic/cache_hit_counter.sv ====
// Cache hit counter
`default_nettype none

module cache_hit_counter (
	input  wire iCLOCK,
	input  wire inRESET,
	input  wire clear,
	input  wire sample,
	input  wire hit,
	output logic [icache_pkg::HIT_COUNT_W-1:0] count
);

	// Sticks at all ones
	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			count <= '0;
		end else if (clear) begin
			count <= '0;
		end else if (sample && hit && (count != '1)) begin
			count <= count + 1'b1;
		end
	end

endmodule

`default_nettype wire

// ==== logic/fetch_matching_queue.sv ====
// Fetch matching queue
`default_nettype none

module fetch_matching_queue (
	input  wire iCLOCK,
	input  wire inRESET,
	input  wire clear,
	input  wire push,
	input  wire pop,
	output logic full,
	output logic nonempty
);

	// Outstanding requests, 0 to QUEUE_DEPTH
	logic [$clog2(icache_pkg::QUEUE_DEPTH+1)-1:0] count_q;

	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			count_q <= '0;
		end else if (clear) begin
			count_q <= '0;
		end else if (push && !pop) begin
			count_q <= count_q + 1'b1;
		end else if (pop && !push) begin
			count_q <= count_q - 1'b1;
		end
	end

	assign full = (count_q == icache_pkg::QUEUE_DEPTH);
	assign nonempty = (count_q != '0);

	// Fetch lock covers the full case
	assert property (@(posedge iCLOCK) disable iff (!inRESET) (push && !clear) |-> !full);
	// Every delivery matches an earlier accepted request
	assert property (@(posedge iCLOCK) disable iff (!inRESET) (pop && !clear) |-> nonempty);

endmodule

`default_nettype wire

// ==== logic/fetch_mmu_pkg.sv ====
// Fetch and MMU widths
`default_nettype none

package fetch_mmu_pkg;

	// Fetch address and instruction word
	localparam int ADDR_W = 32;
	localparam int INST_W = 32;

	// One memory beat holds two instructions
	localparam int BEAT_W = 64;

	// MMU flags per instruction and per beat
	localparam int MMU_FLAGS_W = 14;
	localparam int BEAT_FLAGS_W = 28;

	// Translation mode passed on to memory
	localparam int MMUMOD_W = 2;

endpackage

`default_nettype wire

// ==== logic/icache_pkg.sv ====
// Instruction cache geometry
`default_nettype none

package icache_pkg;

	// Line and memory beat geometry
	localparam int LINE_BYTES = 64;
	localparam int BEATS_PER_LINE = 8;

	// 4-way set associative, 16 sets
	localparam int NUM_SETS = 16;
	localparam int NUM_WAYS = 4;
	localparam int INDEX_W = 4;
	localparam int TAG_W = 22;

	// Side blocks
	localparam int QUEUE_DEPTH = 16;
	localparam int HIT_COUNT_W = 7;

	// Miss and fill controller
	typedef enum logic [1:0] {
		idle,
		memreq,
		memget,
		outinst
	} fill_state_t;

endpackage

`default_nettype wire

// ==== logic/l1_cache_array.sv ====
// 4-way instruction cache array
`default_nettype none

module l1_cache_array (
	input  wire iCLOCK,
	input  wire inRESET,
	input  wire flush,
	// Lookup
	input  wire rd_req,
	input  wire [icache_pkg::INDEX_W-1:0] rd_index,
	input  wire [icache_pkg::TAG_W-1:0] rd_tag,
	input  wire [$clog2(icache_pkg::BEATS_PER_LINE)-1:0] rd_word,
	input  wire hold,
	output logic rd_valid,
	output logic rd_hit,
	output logic [fetch_mmu_pkg::BEAT_W-1:0] rd_data,
	output logic [fetch_mmu_pkg::BEAT_FLAGS_W-1:0] rd_flags,
	// Line fill
	input  wire wr_req,
	input  wire [icache_pkg::INDEX_W-1:0] wr_index,
	input  wire [icache_pkg::TAG_W-1:0] wr_tag,
	input  wire [icache_pkg::LINE_BYTES*8-1:0] wr_line,
	input  wire [icache_pkg::BEATS_PER_LINE*fetch_mmu_pkg::BEAT_FLAGS_W-1:0] wr_line_flags
);

	// Valid bits and replacement pointers per set
	logic [icache_pkg::NUM_SETS-1:0][icache_pkg::NUM_WAYS-1:0] valid_q;
	logic [icache_pkg::NUM_SETS-1:0][$clog2(icache_pkg::NUM_WAYS)-1:0] rr_q;

	logic [icache_pkg::TAG_W-1:0] tag_mem [icache_pkg::NUM_SETS][icache_pkg::NUM_WAYS];
	logic [icache_pkg::LINE_BYTES*8-1:0] data_mem [icache_pkg::NUM_SETS][icache_pkg::NUM_WAYS];
	logic [icache_pkg::BEATS_PER_LINE*fetch_mmu_pkg::BEAT_FLAGS_W-1:0]
		flag_mem [icache_pkg::NUM_SETS][icache_pkg::NUM_WAYS];

	logic [icache_pkg::NUM_WAYS-1:0] hit_vec;
	logic [fetch_mmu_pkg::BEAT_W-1:0] hit_beat;
	logic [fetch_mmu_pkg::BEAT_FLAGS_W-1:0] hit_flags;

	// Tag compare across all ways of the set
	always_comb begin
		for (int w = 0; w < icache_pkg::NUM_WAYS; w++) begin
			hit_vec[w] = valid_q[rd_index][w] && (tag_mem[rd_index][w] == rd_tag);
		end
	end

	// Pick the requested beat out of the hitting line
	always_comb begin
		hit_beat = '0;
		hit_flags = '0;
		for (int w = 0; w < icache_pkg::NUM_WAYS; w++) begin
			if (hit_vec[w]) begin
				hit_beat = data_mem[rd_index][w][rd_word*fetch_mmu_pkg::BEAT_W +:
					fetch_mmu_pkg::BEAT_W];
				hit_flags = flag_mem[rd_index][w][rd_word*fetch_mmu_pkg::BEAT_FLAGS_W +:
					fetch_mmu_pkg::BEAT_FLAGS_W];
			end
		end
	end

	// Valid bits and round-robin victim pointer
	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			valid_q <= '0;
			rr_q <= '0;
		end else if (flush) begin
			valid_q <= '0;
		end else if (wr_req) begin
			valid_q[wr_index][rr_q[wr_index]] <= 1'b1;
			rr_q[wr_index] <= rr_q[wr_index] + 1'b1;
		end
	end

	// Whole line goes in at once
	always_ff @(posedge iCLOCK) begin
		if (wr_req) begin
			tag_mem[wr_index][rr_q[wr_index]] <= wr_tag;
			data_mem[wr_index][rr_q[wr_index]] <= wr_line;
			flag_mem[wr_index][rr_q[wr_index]] <= wr_line_flags;
		end
	end

	// Registered lookup result, frozen while the fetch side holds
	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			rd_valid <= 1'b0;
			rd_hit <= 1'b0;
		end else if (!hold) begin
			rd_valid <= rd_req;
			rd_hit <= rd_req && (|hit_vec);
		end
	end

	always_ff @(posedge iCLOCK) begin
		if (!hold && rd_req) begin
			rd_data <= hit_beat;
			rd_flags <= hit_flags;
		end
	end

	// A line is only ever filled after a miss, so no tag sits in two ways
	assert property (@(posedge iCLOCK) disable iff (!inRESET) rd_req |-> $onehot0(hit_vec));

endmodule

`default_nettype wire

// ==== logic/l1_instruction_cache.sv ====
// L1 instruction cache
`default_nettype none

module l1_instruction_cache (
	input  wire iCLOCK,
	input  wire inRESET,
	input  wire remove,
	input  wire cache_flush,
	// Memory port
	output logic mem_req,
	input  wire mem_lock,
	output logic [fetch_mmu_pkg::MMUMOD_W-1:0] mem_mmumod,
	output logic [fetch_mmu_pkg::ADDR_W-1:0] mem_addr,
	input  wire mem_valid,
	input  wire mem_pagefault,
	input  wire [fetch_mmu_pkg::BEAT_W-1:0] mem_data,
	input  wire [fetch_mmu_pkg::BEAT_FLAGS_W-1:0] mem_mmu_flags,
	// Fetch stage
	input  wire fetch_req,
	output logic fetch_lock,
	input  wire [fetch_mmu_pkg::MMUMOD_W-1:0] fetch_mmumod,
	input  wire [fetch_mmu_pkg::ADDR_W-1:0] fetch_addr,
	output logic inst0_valid,
	output logic inst0_pagefault,
	output logic [fetch_mmu_pkg::MMU_FLAGS_W-1:0] inst0_mmu_flags,
	output logic [fetch_mmu_pkg::INST_W-1:0] inst0,
	output logic inst1_valid,
	output logic inst1_pagefault,
	output logic [fetch_mmu_pkg::MMU_FLAGS_W-1:0] inst1_mmu_flags,
	output logic [fetch_mmu_pkg::INST_W-1:0] inst1,
	input  wire out_lock,
	output logic [icache_pkg::HIT_COUNT_W-1:0] hit_count
);

	icache_pkg::fill_state_t state_q;

	logic [fetch_mmu_pkg::ADDR_W-1:0] req_addr_q;
	logic [fetch_mmu_pkg::MMUMOD_W-1:0] req_mmumod_q;
	// Beats requested and beats returned, 0 to 8
	logic [3:0] req_cnt_q;
	logic [3:0] get_cnt_q;
	logic pagefault_q;

	// Line assembly and the beat holding the requested word
	logic [icache_pkg::LINE_BYTES*8-1:0] line_buf_q;
	logic [icache_pkg::BEATS_PER_LINE*fetch_mmu_pkg::BEAT_FLAGS_W-1:0] line_flags_q;
	logic [fetch_mmu_pkg::BEAT_W-1:0] cap_data_q;
	logic [fetch_mmu_pkg::BEAT_FLAGS_W-1:0] cap_flags_q;

	logic lookup_valid;
	logic lookup_hit;
	logic [fetch_mmu_pkg::BEAT_W-1:0] lookup_data;
	logic [fetch_mmu_pkg::BEAT_FLAGS_W-1:0] lookup_flags;

	logic queue_full;
	logic queue_nonempty;

	logic accept;
	logic filling;
	logic fill_ready;
	logic leave_out;
	logic line_wr_req;
	logic sel0_valid;
	logic sel1_valid;
	logic [fetch_mmu_pkg::BEAT_W-1:0] sel_beat;
	logic [fetch_mmu_pkg::BEAT_FLAGS_W-1:0] sel_flags;

	assign accept = fetch_req && !fetch_lock;
	assign filling = (state_q == icache_pkg::memreq) || (state_q == icache_pkg::memget);

	// Output state waits until every requested beat is back, even after a fault
	assign fill_ready = (state_q == icache_pkg::outinst) && (get_cnt_q == req_cnt_q);
	assign leave_out = fill_ready && !out_lock;
	assign line_wr_req = leave_out && !pagefault_q;

	// Miss and fill controller
	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			state_q <= icache_pkg::idle;
			req_addr_q <= '0;
			req_mmumod_q <= '0;
			req_cnt_q <= '0;
			get_cnt_q <= '0;
			pagefault_q <= 1'b0;
		end else begin
			if (accept) begin
				req_addr_q <= fetch_addr;
				req_mmumod_q <= fetch_mmumod;
			end
			if (mem_req) begin
				req_cnt_q <= req_cnt_q + 4'd1;
			end
			if (mem_valid && (filling || state_q == icache_pkg::outinst)) begin
				get_cnt_q <= get_cnt_q + 4'd1;
			end
			case (state_q)
				icache_pkg::idle: begin
					req_cnt_q <= '0;
					get_cnt_q <= '0;
					pagefault_q <= 1'b0;
					if (lookup_valid && !lookup_hit && !out_lock) begin
						state_q <= icache_pkg::memreq;
					end
				end
				icache_pkg::memreq: begin
					if (mem_valid && mem_pagefault) begin
						state_q <= icache_pkg::outinst;
						pagefault_q <= 1'b1;
					end else if (mem_req && req_cnt_q == 4'd7) begin
						state_q <= icache_pkg::memget;
					end
				end
				icache_pkg::memget: begin
					if (mem_valid && mem_pagefault) begin
						state_q <= icache_pkg::outinst;
						pagefault_q <= 1'b1;
					end else if (mem_valid && get_cnt_q == 4'd7) begin
						state_q <= icache_pkg::outinst;
					end
				end
				icache_pkg::outinst: begin
					if (leave_out) begin
						state_q <= icache_pkg::idle;
					end
				end
				default: begin
					state_q <= icache_pkg::idle;
				end
			endcase
		end
	end

	// Beats arrive in order and shift down from the top
	always_ff @(posedge iCLOCK) begin
		if (filling && mem_valid) begin
			line_buf_q <= {mem_data,
				line_buf_q[icache_pkg::LINE_BYTES*8-1:fetch_mmu_pkg::BEAT_W]};
			line_flags_q <= {mem_mmu_flags,
				line_flags_q[icache_pkg::BEATS_PER_LINE*fetch_mmu_pkg::BEAT_FLAGS_W-1:
				fetch_mmu_pkg::BEAT_FLAGS_W]};
			if ((get_cnt_q[2:0] == req_addr_q[5:3]) || mem_pagefault) begin
				cap_data_q <= mem_data;
				cap_flags_q <= mem_mmu_flags;
			end
		end
	end

	// Refilled beat in the output state, lookup result otherwise
	always_comb begin
		if (state_q == icache_pkg::outinst) begin
			sel_beat = cap_data_q;
			sel_flags = cap_flags_q;
			sel0_valid = fill_ready;
		end else begin
			sel_beat = lookup_data;
			sel_flags = lookup_flags;
			sel0_valid = lookup_valid && lookup_hit;
		end
		sel1_valid = sel0_valid && !req_addr_q[2];
	end

	// Odd word address delivers only the high word in slot 0
	assign inst0 = req_addr_q[2] ? sel_beat[63:32] : sel_beat[31:0];
	assign inst0_mmu_flags = req_addr_q[2] ? sel_flags[27:14] : sel_flags[13:0];
	assign inst1 = sel_beat[63:32];
	assign inst1_mmu_flags = sel_flags[27:14];

	assign inst0_valid = sel0_valid && !out_lock && queue_nonempty;
	assign inst1_valid = sel1_valid && !out_lock && queue_nonempty;
	assign inst0_pagefault = pagefault_q;
	assign inst1_pagefault = pagefault_q;

	assign fetch_lock = (state_q != icache_pkg::idle) || out_lock || queue_full
		|| (lookup_valid && !lookup_hit);

	assign mem_req = (state_q == icache_pkg::memreq) && !mem_lock;
	assign mem_addr = {req_addr_q[fetch_mmu_pkg::ADDR_W-1:6], req_cnt_q[2:0], 3'b000};
	assign mem_mmumod = req_mmumod_q;

	l1_cache_array l1_cache_array_inst (
		.iCLOCK(iCLOCK),
		.inRESET(inRESET),
		.flush(cache_flush),
		.rd_req(accept),
		.rd_index(fetch_addr[6 +: icache_pkg::INDEX_W]),
		.rd_tag(fetch_addr[fetch_mmu_pkg::ADDR_W-1 -: icache_pkg::TAG_W]),
		.rd_word(fetch_addr[5:3]),
		.hold(out_lock),
		.rd_valid(lookup_valid),
		.rd_hit(lookup_hit),
		.rd_data(lookup_data),
		.rd_flags(lookup_flags),
		.wr_req(line_wr_req),
		.wr_index(req_addr_q[6 +: icache_pkg::INDEX_W]),
		.wr_tag(req_addr_q[fetch_mmu_pkg::ADDR_W-1 -: icache_pkg::TAG_W]),
		.wr_line(line_buf_q),
		.wr_line_flags(line_flags_q)
	);

	fetch_matching_queue fetch_matching_queue_inst (
		.iCLOCK(iCLOCK),
		.inRESET(inRESET),
		.clear(remove),
		.push(accept),
		.pop(inst0_valid),
		.full(queue_full),
		.nonempty(queue_nonempty)
	);

	cache_hit_counter cache_hit_counter_inst (
		.iCLOCK(iCLOCK),
		.inRESET(inRESET),
		.clear(cache_flush),
		.sample(lookup_valid && !out_lock),
		.hit(lookup_hit),
		.count(hit_count)
	);

	// Memory request only when the port is free
	assert property (@(posedge iCLOCK) disable iff (!inRESET) !(mem_req && mem_lock));

	// A faulting beat ends the fill and the partial line is never written
	assert property (@(posedge iCLOCK) disable iff (!inRESET)
		(filling && mem_valid && mem_pagefault)
		|=> (pagefault_q && state_q == icache_pkg::outinst));
	assert property (@(posedge iCLOCK) disable iff (!inRESET) line_wr_req |-> !pagefault_q);

endmodule

`default_nettype wire

// ==== run_sim.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
	--top-module tb_l1_instruction_cache -f sim.f -o sim_l1_instruction_cache

if ! output=$(./obj_dir/sim_l1_instruction_cache 2>&1); then
	echo "$output"
	exit 1
fi
echo "$output"

if echo "$output" | grep -q "Simulation finished: PASS"; then
	exit 0
fi
exit 1

// ==== sim.f ====
logic/icache_pkg.sv
logic/fetch_mmu_pkg.sv
logic/l1_cache_array.sv
logic/fetch_matching_queue.sv
logic/cache_hit_counter.sv
logic/l1_instruction_cache.sv
tb/inst_memory_model.sv
tb/tb_l1_instruction_cache.sv

// ==== tb/inst_memory_model.sv ====
// Instruction memory model
`default_nettype none

module inst_memory_model (
	input  wire iCLOCK,
	input  wire inRESET,
	input  wire mem_req,
	input  wire [fetch_mmu_pkg::ADDR_W-1:0] mem_addr,
	output logic mem_lock,
	output logic mem_valid,
	output logic [fetch_mmu_pkg::BEAT_W-1:0] mem_data,
	output logic [fetch_mmu_pkg::BEAT_FLAGS_W-1:0] mem_mmu_flags,
	output logic mem_pagefault
);
	timeunit 1ns;
	timeprecision 1ps;

	// Beat addresses taken but not yet returned
	logic [fetch_mmu_pkg::ADDR_W-1:0] pending [$];
	logic [fetch_mmu_pkg::ADDR_W-1:0] beat_addr;

	function automatic logic [31:0] word_at(input logic [31:0] a);
		return a ^ 32'h5A5A0000;
	endfunction

	function automatic logic [13:0] flags_at(input logic [31:0] a);
		return a[15:2];
	endfunction

	initial begin
		mem_lock = 1'b0;
		mem_valid = 1'b0;
		mem_data = '0;
		mem_mmu_flags = '0;
		mem_pagefault = 1'b0;
	end

	// Requests taken on the rising edge
	always @(posedge iCLOCK) begin
		if (!inRESET) begin
			pending.delete();
		end else if (mem_req && !mem_lock) begin
			pending.push_back(mem_addr);
		end
	end

	// Random lock and random gaps between returned beats
	always @(negedge iCLOCK) begin
		mem_lock = ($urandom % 4) == 0;
		mem_valid = 1'b0;
		mem_pagefault = 1'b0;
		if (inRESET && pending.size() != 0 && ($urandom % 3) != 0) begin
			beat_addr = pending.pop_front();
			mem_valid = 1'b1;
			mem_data = {word_at(beat_addr + 32'd4), word_at(beat_addr)};
			mem_mmu_flags = {flags_at(beat_addr + 32'd4), flags_at(beat_addr)};
			// Whole top page faults
			mem_pagefault = beat_addr[31:12] == 20'hFFFFF;
		end
	end

endmodule

`default_nettype wire

// ==== tb/tb_l1_instruction_cache.sv ====
// L1 instruction cache testbench
`default_nettype none

module tb_l1_instruction_cache;
	timeunit 1ns;
	timeprecision 1ps;

	localparam int CLK_PERIOD = 20;
	localparam int NUM_ROWS = 18;
	localparam int CYCLES_PER_ROW = 200;
	localparam int QUIET_CYCLES = 3;

	logic iCLOCK;
	logic inRESET;
	logic remove;
	logic cache_flush;
	logic mem_req;
	logic mem_lock;
	logic [fetch_mmu_pkg::MMUMOD_W-1:0] mem_mmumod;
	logic [fetch_mmu_pkg::ADDR_W-1:0] mem_addr;
	logic mem_valid;
	logic mem_pagefault;
	logic [fetch_mmu_pkg::BEAT_W-1:0] mem_data;
	logic [fetch_mmu_pkg::BEAT_FLAGS_W-1:0] mem_mmu_flags;
	logic fetch_req;
	logic fetch_lock;
	logic [fetch_mmu_pkg::MMUMOD_W-1:0] fetch_mmumod;
	logic [fetch_mmu_pkg::ADDR_W-1:0] fetch_addr;
	logic inst0_valid;
	logic inst0_pagefault;
	logic [fetch_mmu_pkg::MMU_FLAGS_W-1:0] inst0_mmu_flags;
	logic [fetch_mmu_pkg::INST_W-1:0] inst0;
	logic inst1_valid;
	logic inst1_pagefault;
	logic [fetch_mmu_pkg::MMU_FLAGS_W-1:0] inst1_mmu_flags;
	logic [fetch_mmu_pkg::INST_W-1:0] inst1;
	logic out_lock;
	logic [icache_pkg::HIT_COUNT_W-1:0] hit_count;

	// Stimulus table
	string row_name [NUM_ROWS];
	logic [31:0] row_addr [NUM_ROWS];
	logic row_flush [NUM_ROWS];
	logic row_hold [NUM_ROWS];
	logic row_fault [NUM_ROWS];
	logic [31:0] row_inst0 [NUM_ROWS];
	logic [31:0] row_inst1 [NUM_ROWS];
	int row_hits [NUM_ROWS];
	int row_count;
	int mismatch_count;
	int failure_count;

	l1_instruction_cache l1_instruction_cache_inst (
		.iCLOCK(iCLOCK),
		.inRESET(inRESET),
		.remove(remove),
		.cache_flush(cache_flush),
		.mem_req(mem_req),
		.mem_lock(mem_lock),
		.mem_mmumod(mem_mmumod),
		.mem_addr(mem_addr),
		.mem_valid(mem_valid),
		.mem_pagefault(mem_pagefault),
		.mem_data(mem_data),
		.mem_mmu_flags(mem_mmu_flags),
		.fetch_req(fetch_req),
		.fetch_lock(fetch_lock),
		.fetch_mmumod(fetch_mmumod),
		.fetch_addr(fetch_addr),
		.inst0_valid(inst0_valid),
		.inst0_pagefault(inst0_pagefault),
		.inst0_mmu_flags(inst0_mmu_flags),
		.inst0(inst0),
		.inst1_valid(inst1_valid),
		.inst1_pagefault(inst1_pagefault),
		.inst1_mmu_flags(inst1_mmu_flags),
		.inst1(inst1),
		.out_lock(out_lock),
		.hit_count(hit_count)
	);

	inst_memory_model inst_memory_model (
		.iCLOCK(iCLOCK),
		.inRESET(inRESET),
		.mem_req(mem_req),
		.mem_addr(mem_addr),
		.mem_lock(mem_lock),
		.mem_valid(mem_valid),
		.mem_data(mem_data),
		.mem_mmu_flags(mem_mmu_flags),
		.mem_pagefault(mem_pagefault)
	);

	initial begin
		iCLOCK = 1'b0;
		forever #(CLK_PERIOD / 2) iCLOCK = ~iCLOCK;
	end

	// Memory pattern, word and flags by byte address
	function automatic logic [31:0] expected_word(input logic [31:0] a);
		return a ^ 32'h5A5A0000;
	endfunction

	function automatic logic [31:0] expected_flags(input logic [31:0] a);
		return {18'd0, a[15:2]};
	endfunction

	task automatic check_value(input string test, input string what,
		input logic [31:0] expected, input logic [31:0] actual);
		assert (actual === expected) else begin
			$display("MISMATCH %s %s expected %h actual %h", test, what, expected, actual);
			mismatch_count++;
		end
	endtask

	task automatic add_row(input string name, input logic [31:0] addr, input logic flush,
		input logic hold, input logic fault, input int hits);
		row_name[row_count] = name;
		row_addr[row_count] = addr;
		row_flush[row_count] = flush;
		row_hold[row_count] = hold;
		row_fault[row_count] = fault;
		row_inst0[row_count] = expected_word(addr);
		row_inst1[row_count] = expected_word(addr + 32'd4);
		row_hits[row_count] = hits;
		row_count++;
	endtask

	task automatic build_table();
		// Name, address, flush, hold, fault, hit count after the row
		add_row("miss_pair", 32'h0000_1000, 1'b0, 1'b0, 1'b0, 0);
		add_row("miss_single", 32'h0000_2044, 1'b0, 1'b0, 1'b0, 0);
		add_row("hit_pair", 32'h0000_1008, 1'b0, 1'b0, 1'b0, 1);
		add_row("hit_line_base", 32'h0000_2040, 1'b0, 1'b0, 1'b0, 2);
		add_row("hit_single", 32'h0000_101C, 1'b0, 1'b0, 1'b0, 3);
		add_row("fault_first", 32'hFFFF_F000, 1'b0, 1'b0, 1'b1, 3);
		add_row("fault_refetch", 32'hFFFF_F000, 1'b0, 1'b0, 1'b1, 3);
		add_row("flush_refetch", 32'h0000_1008, 1'b1, 1'b0, 1'b0, 0);
		add_row("refill_hit", 32'h0000_1010, 1'b0, 1'b0, 1'b0, 1);
		// Five tags on set 5
		add_row("evict_fill_a", 32'h0001_0140, 1'b0, 1'b0, 1'b0, 1);
		add_row("evict_fill_b", 32'h0001_0540, 1'b0, 1'b0, 1'b0, 1);
		add_row("evict_fill_c", 32'h0001_0940, 1'b0, 1'b0, 1'b0, 1);
		add_row("evict_fill_d", 32'h0001_0D40, 1'b0, 1'b0, 1'b0, 1);
		add_row("evict_fill_e", 32'h0001_1140, 1'b0, 1'b0, 1'b0, 1);
		add_row("evict_fifth_hit", 32'h0001_1148, 1'b0, 1'b0, 1'b0, 2);
		add_row("evict_first_miss", 32'h0001_0144, 1'b0, 1'b0, 1'b0, 2);
		add_row("hold_hit_pair", 32'h0001_1150, 1'b0, 1'b1, 1'b0, 3);
		add_row("hold_hit_single", 32'h0000_1014, 1'b0, 1'b1, 1'b0, 4);
	endtask

	task automatic check_delivery(input int i);
		check_value(row_name[i], "inst0", row_inst0[i], inst0);
		check_value(row_name[i], "inst0_mmu_flags", expected_flags(row_addr[i]),
			{18'd0, inst0_mmu_flags});
		check_value(row_name[i], "inst1_valid", {31'd0, !row_addr[i][2]}, {31'd0, inst1_valid});
		if (!row_addr[i][2]) begin
			check_value(row_name[i], "inst1", row_inst1[i], inst1);
			check_value(row_name[i], "inst1_mmu_flags", expected_flags(row_addr[i] + 32'd4),
				{18'd0, inst1_mmu_flags});
		end
		check_value(row_name[i], "inst0_pagefault", {31'd0, row_fault[i]},
			{31'd0, inst0_pagefault});
		check_value(row_name[i], "inst1_pagefault", {31'd0, row_fault[i]},
			{31'd0, inst1_pagefault});
	endtask

	task automatic apply_row(input int i);
		int hold_cycles;
		logic [1:0] mode;
		logic [31:0] beat_addr;
		mode = 2'(i + 1);
		beat_addr = {row_addr[i][31:6], 6'd0};
		@(negedge iCLOCK);
		if (row_flush[i]) begin
			cache_flush = 1'b1;
			@(negedge iCLOCK);
			cache_flush = 1'b0;
		end
		while (fetch_lock) begin
			@(negedge iCLOCK);
		end
		fetch_addr = row_addr[i];
		fetch_mmumod = mode;
		fetch_req = 1'b1;
		// Taken on the rising edge in between
		@(negedge iCLOCK);
		fetch_req = 1'b0;
		// Memory must see the mode of the accepted request
		fetch_mmumod = ~mode;
		if (row_hold[i]) begin
			hold_cycles = 1 + ($urandom % 8);
			out_lock = 1'b1;
			for (int c = 0; c < hold_cycles; c++) begin
				#(CLK_PERIOD / 4);
				assert (!inst0_valid && !inst1_valid) else begin
					$display("Error in %s: a valid output was high while out_lock was held",
						row_name[i]);
					failure_count++;
				end
				check_value(row_name[i], "held inst0", row_inst0[i], inst0);
				if (!row_addr[i][2]) begin
					check_value(row_name[i], "held inst1", row_inst1[i], inst1);
				end
				@(negedge iCLOCK);
			end
			out_lock = 1'b0;
		end
		// Sample a quarter period after the falling edge
		#(CLK_PERIOD / 4);
		while (!inst0_valid) begin
			// Beats of the line go out in ascending order
			if (mem_req) begin
				check_value(row_name[i], "mem_mmumod", {30'd0, mode}, {30'd0, mem_mmumod});
				check_value(row_name[i], "mem_addr", beat_addr, mem_addr);
				beat_addr += 32'd8;
			end
			@(negedge iCLOCK);
			#(CLK_PERIOD / 4);
		end
		check_delivery(i);
		repeat (QUIET_CYCLES) begin
			@(negedge iCLOCK);
			#(CLK_PERIOD / 4);
			assert (!inst0_valid && !inst1_valid) else begin
				$display("Error in %s: the outputs became valid again after the delivery",
					row_name[i]);
				failure_count++;
			end
		end
		check_value(row_name[i], "hit_count", row_hits[i], {25'd0, hit_count});
	endtask

	// Watchdog
	initial begin
		#(NUM_ROWS * CYCLES_PER_ROW * CLK_PERIOD);
		$display("Timeout: the tests did not finish within %0d cycles",
			NUM_ROWS * CYCLES_PER_ROW);
		$display("Simulation finished: FAIL");
		$finish;
	end

	initial begin
		void'($urandom(32'h413e8559));
		inRESET = 1'b0;
		remove = 1'b0;
		cache_flush = 1'b0;
		fetch_req = 1'b0;
		fetch_mmumod = '0;
		fetch_addr = '0;
		out_lock = 1'b0;
		mismatch_count = 0;
		failure_count = 0;
		row_count = 0;
		build_table();
		repeat (5) @(negedge iCLOCK);
		check_value("after_reset", "fetch_lock", 32'd0, {31'd0, fetch_lock});
		check_value("after_reset", "mem_req", 32'd0, {31'd0, mem_req});
		check_value("after_reset", "inst0_valid", 32'd0, {31'd0, inst0_valid});
		check_value("after_reset", "inst1_valid", 32'd0, {31'd0, inst1_valid});
		check_value("after_reset", "inst0_pagefault", 32'd0, {31'd0, inst0_pagefault});
		check_value("after_reset", "inst1_pagefault", 32'd0, {31'd0, inst1_pagefault});
		inRESET = 1'b1;
		for (int i = 0; i < NUM_ROWS; i++) begin
			apply_row(i);
		end
		$display("Errors: %0d mismatches, %0d other failures", mismatch_count, failure_count);
		if (mismatch_count == 0 && failure_count == 0) begin
			$display("Simulation finished: PASS");
		end else begin
			$display("Simulation finished: FAIL");
		end
		$finish;
	end

endmodule

`default_nettype wire
